// ==== all.f ====
rtl/mdpt_pkg.sv
rtl/mdpt_update_if.sv
rtl/mdpt_index_hash.sv
rtl/bram_2rport_1wport.sv
rtl/mdpt.sv
rtl/mdpt_top.sv
sim/mdpt_props.sv
sim/mdpt_checker.sv
sim/mdpt_tb.sv

// ==== Bender.yml ====
package:
  name: mdpt

sources:
  # Design
  - rtl/mdpt_pkg.sv
  - rtl/mdpt_update_if.sv
  - rtl/mdpt_index_hash.sv
  - rtl/bram_2rport_1wport.sv
  - rtl/mdpt.sv
  - rtl/mdpt_top.sv

  # Testbench
  - target: simulation
    files:
      - sim/mdpt_props.sv
      - sim/mdpt_checker.sv
      - sim/mdpt_tb.sv

// ==== sim/mdpt_tb.sv ====
`timescale 1ns/1ps

module mdpt_tb;
    import mdpt_pkg::*;

    localparam int ASID_WIDTH   = DEFAULT_ASID_WIDTH;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_ROWS  = 200;
    localparam int MARGIN       = 200;

    typedef struct packed {
        logic                  lookup;
        logic                  update;
        logic [31:0]           pc;
        logic [ASID_WIDTH-1:0] asid;
        logic                  truth;
        logic                  has_exp;
        logic [7:0]            exp;
    } row_t;

    logic                  CLK;
    logic                  nRST;
    logic                  valid_req;
    logic [31:0]           pc_req;
    logic [ASID_WIDTH-1:0] asid_req;
    logic [7:0]            dep_pred_resp;
    logic                  upd_valid;
    logic [31:0]           upd_start_pc;
    logic [ASID_WIDTH-1:0] upd_asid;
    logic                  upd_dep_truth;
    logic                  tbl_exp_valid;
    logic [7:0]            tbl_exp;
    int                    checks;
    int                    mismatches;
    int                    seed = 85615;
    int                    limit_cycles;
    logic                  table_ready = 1'b0;
    row_t                  rows [$];

    mdpt_top i_dut (
        .CLK           (CLK),
        .nRST          (nRST),
        .valid_req     (valid_req),
        .pc_req        (pc_req),
        .asid_req      (asid_req),
        .dep_pred_resp (dep_pred_resp),
        .upd_valid     (upd_valid),
        .upd_start_pc  (upd_start_pc),
        .upd_asid      (upd_asid),
        .upd_dep_truth (upd_dep_truth)
    );

    mdpt_checker i_checker (
        .CLK           (CLK),
        .nRST          (nRST),
        .valid_req     (valid_req),
        .pc_req        (pc_req),
        .asid_req      (asid_req),
        .dep_pred_resp (dep_pred_resp),
        .upd_valid     (upd_valid),
        .upd_start_pc  (upd_start_pc),
        .upd_asid      (upd_asid),
        .upd_dep_truth (upd_dep_truth),
        .tbl_exp_valid (tbl_exp_valid),
        .tbl_exp       (tbl_exp),
        .checks        (checks),
        .mismatches    (mismatches)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    task automatic add_row(input logic lk, input logic up, input logic [31:0] pc,
                           input logic [ASID_WIDTH-1:0] asid, input logic truth,
                           input logic has_exp, input logic [7:0] exp);
        rows.push_back('{lk, up, pc, asid, truth, has_exp, exp});
    endtask

    // ----------------------------------------
    // Directed rows applied one per cycle

    task automatic build_table();
        // Fresh table
        add_row(1, 0, 32'h0000_1000, 0,     0, 1, 8'h00);
        add_row(1, 0, 32'h1234_5670, 5,     0, 1, 8'h00);
        add_row(1, 0, 32'hFFFF_FFFE, 9'h1FF, 0, 1, 8'h00);
        // Slot 3 trained while the lookup on the write edge still sees the old row
        add_row(0, 1, 32'h0000_1006, 0,     1, 0, 8'h00);
        add_row(1, 0, 32'h0000_1000, 0,     0, 1, 8'h00);
        add_row(1, 0, 32'h0000_100E, 0,     0, 1, 8'h08);
        add_row(1, 0, 32'h0000_1000, 1,     0, 1, 8'h00);
        // 11 -> 10 -> 01 -> 00 -> 00
        for (int k = 0; k < 4; k++) begin
            add_row(0, 1, 32'h0000_1006, 0, 0, 0, 8'h00);
            add_row(0, 0, 32'h0000_0000, 0, 0, 0, 8'h00);
            add_row(1, 0, 32'h0000_1000, 0, 0, 1, (k < 2) ? 8'h08 : 8'h00);
        end
        // Back-to-back updates on one set
        add_row(0, 1, 32'h0000_2002, 3,     1, 0, 8'h00);
        add_row(0, 1, 32'h0000_2004, 3,     1, 0, 8'h00);
        add_row(0, 1, 32'h0000_200C, 3,     1, 0, 8'h00);
        add_row(0, 1, 32'h0000_200C, 3,     0, 0, 8'h00);
        add_row(0, 1, 32'h0000_200C, 3,     0, 0, 8'h00);
        add_row(0, 1, 32'h0000_200C, 3,     0, 0, 8'h00);
        add_row(1, 0, 32'h0000_2000, 3,     0, 1, 8'h46);
        add_row(1, 0, 32'h0000_2000, 3,     0, 1, 8'h06);
        // Lookups with the update, on its write edge and one edge later
        add_row(1, 1, 32'h0000_200C, 3,     1, 1, 8'h06);
        add_row(1, 0, 32'h0000_2000, 3,     0, 1, 8'h06);
        add_row(1, 0, 32'h0000_2000, 3,     0, 1, 8'h46);
        add_row(1, 0, 32'h0000_1000, 0,     0, 1, 8'h00);
        add_row(0, 0, 32'h0000_0000, 0,     0, 0, 8'h00);
    endtask

    // Narrow pc and asid range so sets collide often
    task automatic add_random_rows();
        row_t r;
        int   draw;
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            draw      = $random(seed);
            r.lookup  = draw[0];
            r.update  = draw[1];
            r.truth   = draw[2];
            r.asid    = ASID_WIDTH'(draw[4:3]);
            r.pc      = 32'h0000_1000 | (32'($random(seed)) & 32'h0000_003F);
            r.has_exp = 1'b0;
            r.exp     = 8'h00;
            rows.push_back(r);
        end
    endtask

    task automatic drive_row(input row_t r);
        valid_req     <= r.lookup;
        pc_req        <= r.pc;
        asid_req      <= r.asid;
        upd_valid     <= r.update;
        upd_start_pc  <= r.pc;
        upd_asid      <= r.asid;
        upd_dep_truth <= r.truth;
        tbl_exp_valid <= r.lookup & r.has_exp;
        tbl_exp       <= r.exp;
    endtask

    // ----------------------------------------
    // Main sequence

    initial begin
        nRST          = 1'b0;
        valid_req     = 1'b0;
        pc_req        = '0;
        asid_req      = '0;
        upd_valid     = 1'b0;
        upd_start_pc  = '0;
        upd_asid      = '0;
        upd_dep_truth = 1'b0;
        tbl_exp_valid = 1'b0;
        tbl_exp       = '0;
        build_table();
        add_random_rows();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        foreach (rows[i]) begin
            @(posedge CLK);
            drive_row(rows[i]);
        end
        @(posedge CLK);
        drive_row('0);
        repeat (3) @(posedge CLK);
        @(negedge CLK);

        if (checks == 0) begin
            $display("No response checks were made");
        end
        $display("Summary: checks=%0d mismatches=%0d assertion_failures=%0d",
                 checks, mismatches, i_dut.i_mdpt.i_props.fail_count);
        if (checks > 0 && mismatches == 0 && i_dut.i_mdpt.i_props.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the stimulus length
    initial begin
        wait (table_ready);
        limit_cycles = rows.size() + RESET_CYCLES + MARGIN;
        #(limit_cycles * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", limit_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== sim/mdpt_checker.sv ====
`timescale 1ns/1ps

module mdpt_checker #(
    parameter int MDPT_SETS  = mdpt_pkg::DEFAULT_MDPT_SETS,
    parameter int ASID_WIDTH = mdpt_pkg::DEFAULT_ASID_WIDTH
) (
    input  logic                                        CLK,
    input  logic                                        nRST,
    input  logic                                        valid_req,
    input  logic [31:0]                                 pc_req,
    input  logic [ASID_WIDTH-1:0]                       asid_req,
    input  logic [mdpt_pkg::MDPT_ENTRIES_PER_BLOCK-1:0] dep_pred_resp,
    input  logic                                        upd_valid,
    input  logic [31:0]                                 upd_start_pc,
    input  logic [ASID_WIDTH-1:0]                       upd_asid,
    input  logic                                        upd_dep_truth,
    // Expected response from the stimulus table where the row has one
    input  logic                                        tbl_exp_valid,
    input  logic [mdpt_pkg::MDPT_ENTRIES_PER_BLOCK-1:0] tbl_exp,
    output int                                          checks,
    output int                                          mismatches
);
    import mdpt_pkg::*;

    localparam int IW = $clog2(MDPT_SETS);

    logic [1:0]                        ctr [MDPT_SETS][MDPT_ENTRIES_PER_BLOCK];
    logic [MDPT_ENTRIES_PER_BLOCK-1:0] exp_resp;
    logic                              tbl_check;
    logic [MDPT_ENTRIES_PER_BLOCK-1:0] tbl_value;
    logic                              pend_valid;
    logic [IW-1:0]                     pend_set;
    logic [2:0]                        pend_slot;
    logic                              pend_truth;
    logic [IW-1:0]                     look_set;

    // Each PC bit above the slot field lands on index bit (b-4) mod IW
    function automatic logic [IW-1:0] set_of(pc_view_t pc, logic [ASID_WIDTH-1:0] asid);
        logic [IW-1:0] idx;
        int            b;
        idx = '0;
        for (b = 4; b < 32; b++) begin
            idx[(b - 4) % IW] ^= pc.flat[b];
        end
        for (b = 0; b < ASID_WIDTH && b < IW; b++) begin
            idx[b] ^= asid[b];
        end
        return idx;
    endfunction

    // ----------------------------------------
    // Reference model

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < MDPT_SETS; s++) begin
                for (int e = 0; e < MDPT_ENTRIES_PER_BLOCK; e++) begin
                    ctr[s][e] = 2'b00;
                end
            end
            exp_resp   = '0;
            tbl_check  = 1'b0;
            tbl_value  = '0;
            pend_valid = 1'b0;
        end else begin
            // Lookup reads before this edge's write
            tbl_check = 1'b0;
            if (valid_req) begin
                look_set = set_of(pc_req, asid_req);
                for (int e = 0; e < MDPT_ENTRIES_PER_BLOCK; e++) begin
                    exp_resp[e] = ctr[look_set][e] != 2'b00;
                end
                tbl_check = tbl_exp_valid;
                tbl_value = tbl_exp;
            end
            // Write of the update taken on the previous edge
            if (pend_valid) begin
                if (pend_truth) begin
                    ctr[pend_set][pend_slot] = 2'b11;
                end else if (ctr[pend_set][pend_slot] != 2'b00) begin
                    ctr[pend_set][pend_slot] = ctr[pend_set][pend_slot] - 2'b01;
                end
            end
            pend_valid = upd_valid;
            pend_set   = set_of(upd_start_pc, upd_asid);
            pend_slot  = upd_start_pc[3:1];
            pend_truth = upd_dep_truth;
        end
    end

    // ----------------------------------------
    // Compare at mid-cycle where the response is stable

    initial begin
        checks     = 0;
        mismatches = 0;
    end

    always @(negedge CLK) begin
        if (nRST) begin
            checks++;
            if (dep_pred_resp !== exp_resp) begin
                mismatches++;
                $display("MISMATCH t=%0t dep_pred_resp expected=%02h actual=%02h (model)",
                         $time, exp_resp, dep_pred_resp);
            end
            if (tbl_check && dep_pred_resp !== tbl_value) begin
                mismatches++;
                $display("MISMATCH t=%0t dep_pred_resp expected=%02h actual=%02h (table)",
                         $time, tbl_value, dep_pred_resp);
            end
        end
    end

endmodule

// ==== sim/mdpt_props.sv ====
`timescale 1ns/1ps

module mdpt_props (
    input logic                                                CLK,
    input logic                                                nRST,
    input logic                                                valid_req,
    input logic                                                upd_valid,
    input logic                                                upd1_valid,
    input logic [(mdpt_pkg::MDPT_ENTRIES_PER_BLOCK*2+7)/8-1:0] wen_byte,
    input logic [mdpt_pkg::MDPT_ENTRIES_PER_BLOCK-1:0]         dep_pred_resp
);

    logic lookup_seen;
    logic write_seen;
    int   fail_count = 0;

    // History since the last reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lookup_seen <= 1'b0;
            write_seen  <= 1'b0;
        end else begin
            if (valid_req) begin
                lookup_seen <= 1'b1;
            end
            if (upd1_valid) begin
                write_seen <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Properties

    a_stage1_idle_in_reset: assert property (
        @(posedge CLK) !nRST |-> !upd1_valid
    ) else begin
        $error("update stage 1 valid is high during reset");
        fail_count++;
    end

    // Fresh table predicts nothing
    a_first_lookup_zero: assert property (
        @(posedge CLK) disable iff (!nRST)
        (valid_req && !lookup_seen && !write_seen) |=> (dep_pred_resp == '0)
    ) else begin
        $error("first lookup after reset returned a non-zero prediction");
        fail_count++;
    end

    // Each update writes its row on the next edge and only then
    a_write_after_update: assert property (
        @(posedge CLK) disable iff (!nRST)
        wen_byte == {$bits(wen_byte){$past(upd_valid)}}
    ) else begin
        $error("write byte enables do not follow the update of the previous edge");
        fail_count++;
    end

endmodule

bind mdpt mdpt_props i_props (
    .CLK           (CLK),
    .nRST          (nRST),
    .valid_req     (valid_req),
    .upd_valid     (upd.valid),
    .upd1_valid    (upd1_valid),
    .wen_byte      (upd1_wen_byte),
    .dep_pred_resp (dep_pred_resp)
);

// ==== rtl/mdpt_top.sv ====
`timescale 1ns/1ps

module mdpt_top #(
    parameter int MDPT_SETS  = mdpt_pkg::DEFAULT_MDPT_SETS,
    parameter int ASID_WIDTH = mdpt_pkg::DEFAULT_ASID_WIDTH
) (
    input  logic                                        CLK,
    input  logic                                        nRST,

    // Lookup
    input  logic                                        valid_req,
    input  logic [31:0]                                 pc_req,
    input  logic [ASID_WIDTH-1:0]                       asid_req,
    output logic [mdpt_pkg::MDPT_ENTRIES_PER_BLOCK-1:0] dep_pred_resp,

    // Dependence update
    input  logic                                        upd_valid,
    input  logic [31:0]                                 upd_start_pc,
    input  logic [ASID_WIDTH-1:0]                       upd_asid,
    input  logic                                        upd_dep_truth
);

    // ----------------------------------------
    // Update bundle

    mdpt_update_if #(
        .ASID_WIDTH (ASID_WIDTH)
    ) upd_if ();

    assign upd_if.valid          = upd_valid;
    assign upd_if.start_pc.flat  = upd_start_pc;
    assign upd_if.asid           = upd_asid;
    assign upd_if.dep_truth      = upd_dep_truth;

    // ----------------------------------------
    // Prediction table

    mdpt #(
        .MDPT_SETS  (MDPT_SETS),
        .ASID_WIDTH (ASID_WIDTH)
    ) i_mdpt (
        .CLK           (CLK),
        .nRST          (nRST),
        .valid_req     (valid_req),
        .pc_req        (pc_req),
        .asid_req      (asid_req),
        .dep_pred_resp (dep_pred_resp),
        .upd           (upd_if.sink)
    );

endmodule

// ==== rtl/mdpt.sv ====
`timescale 1ns/1ps

module mdpt #(
    parameter int MDPT_SETS  = mdpt_pkg::DEFAULT_MDPT_SETS,
    parameter int ASID_WIDTH = mdpt_pkg::DEFAULT_ASID_WIDTH
) (
    input  logic                                        CLK,
    input  logic                                        nRST,

    // Lookup request
    input  logic                                        valid_req,
    input  mdpt_pkg::pc_view_t                          pc_req,
    input  logic [ASID_WIDTH-1:0]                       asid_req,

    // Lookup response one edge after the request
    output logic [mdpt_pkg::MDPT_ENTRIES_PER_BLOCK-1:0] dep_pred_resp,

    // Training stream
    mdpt_update_if.sink                                 upd
);
    import mdpt_pkg::*;

    localparam int INDEX_WIDTH = $clog2(MDPT_SETS);
    localparam int ROW_WIDTH   = MDPT_ENTRIES_PER_BLOCK * 2;
    localparam int NUM_BYTES   = (ROW_WIDTH + 7) / 8;

    // ----------------------------------------
    // Signals

    // Lookup path
    logic [INDEX_WIDTH-1:0]                   req_index;
    logic [MDPT_ENTRIES_PER_BLOCK-1:0][1:0]   resp_row;

    // Update stage 0
    logic [INDEX_WIDTH-1:0]                   upd0_index;
    logic [LOG_MDPT_ENTRIES_PER_BLOCK-1:0]    upd0_slot;

    // Update stage 1
    logic                                     upd1_valid;
    logic [INDEX_WIDTH-1:0]                   upd1_index;
    logic [LOG_MDPT_ENTRIES_PER_BLOCK-1:0]    upd1_slot;
    logic                                     upd1_truth;
    logic [MDPT_ENTRIES_PER_BLOCK-1:0][1:0]   upd1_old_row;
    logic [MDPT_ENTRIES_PER_BLOCK-1:0][1:0]   upd1_base_row;
    logic [MDPT_ENTRIES_PER_BLOCK-1:0][1:0]   upd1_new_row;
    logic [1:0]                               upd1_cur_ctr;
    logic [NUM_BYTES-1:0]                     upd1_wen_byte;

    // Forwarding of the row written last cycle
    logic                                     last_conflict;
    logic [MDPT_ENTRIES_PER_BLOCK-1:0][1:0]   last_row;

    // ----------------------------------------
    // Lookup path

    mdpt_index_hash #(
        .MDPT_SETS  (MDPT_SETS),
        .ASID_WIDTH (ASID_WIDTH)
    ) i_req_hash (
        .pc    (pc_req),
        .asid  (asid_req),
        .index (req_index)
    );

    // Predict a dependence for any non-zero counter
    always_comb begin
        for (int i = 0; i < MDPT_ENTRIES_PER_BLOCK; i++) begin
            dep_pred_resp[i] = |resp_row[i];
        end
    end

    // ----------------------------------------
    // Update stage 0

    mdpt_index_hash #(
        .MDPT_SETS  (MDPT_SETS),
        .ASID_WIDTH (ASID_WIDTH)
    ) i_upd_hash (
        .pc    (upd.start_pc),
        .asid  (upd.asid),
        .index (upd0_index)
    );

    assign upd0_slot = upd.start_pc.fields.slot;

    // ----------------------------------------
    // Update stage 1

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            upd1_valid    <= 1'b0;
            last_conflict <= 1'b0;
        end else begin
            upd1_valid    <= upd.valid;
            // Same set as the row being written this cycle
            last_conflict <= upd.valid & upd1_valid & (upd0_index == upd1_index);
        end
    end

    // Payload captured only with a live update
    always_ff @(posedge CLK) begin
        if (upd.valid) begin
            upd1_index <= upd0_index;
            upd1_slot  <= upd0_slot;
            upd1_truth <= upd.dep_truth;
        end
        if (upd1_valid) begin
            last_row <= upd1_new_row;
        end
    end

    // RAM row is stale after a same-set write on the previous edge
    assign upd1_base_row = last_conflict ? last_row : upd1_old_row;
    assign upd1_cur_ctr  = upd1_base_row[upd1_slot];

    // True jumps to 11, false steps down and saturates at 00
    always_comb begin
        upd1_new_row = upd1_base_row;
        if (upd1_truth) begin
            upd1_new_row[upd1_slot] = 2'b11;
        end else if (upd1_cur_ctr != 2'b00) begin
            upd1_new_row[upd1_slot] = upd1_cur_ctr - 2'b01;
        end
    end

    // Whole row written back
    assign upd1_wen_byte = {NUM_BYTES{upd1_valid}};

    // ----------------------------------------
    // Counter storage

    // Port 0 serves lookups and port 1 the update read
    bram_2rport_1wport #(
        .INNER_WIDTH (ROW_WIDTH),
        .OUTER_WIDTH (MDPT_SETS)
    ) i_bram (
        .CLK          (CLK),
        .nRST         (nRST),
        .port0_ren    (valid_req),
        .port0_rindex (req_index),
        .port0_rdata  (resp_row),
        .port1_ren    (upd.valid),
        .port1_rindex (upd0_index),
        .port1_rdata  (upd1_old_row),
        .wen_byte     (upd1_wen_byte),
        .windex       (upd1_index),
        .wdata        (upd1_new_row)
    );

endmodule

// ==== rtl/bram_2rport_1wport.sv ====
`timescale 1ns/1ps

module bram_2rport_1wport #(
    parameter int INNER_WIDTH = 16,
    parameter int OUTER_WIDTH = 512
) (
    input  logic                           CLK,
    input  logic                           nRST,

    // Read port 0
    input  logic                           port0_ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] port0_rindex,
    output logic [INNER_WIDTH-1:0]         port0_rdata,

    // Read port 1
    input  logic                           port1_ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] port1_rindex,
    output logic [INNER_WIDTH-1:0]         port1_rdata,

    // Write port
    input  logic [(INNER_WIDTH+7)/8-1:0]   wen_byte,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // ----------------------------------------
    // Write port

    // Cleared on reset like a block RAM loaded with an init file
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int r = 0; r < OUTER_WIDTH; r++) begin
                mem[r] <= '0;
            end
        end else begin
            // Bits of a partial top byte follow that byte's enable
            for (int i = 0; i < INNER_WIDTH; i++) begin
                if (wen_byte[i/8]) begin
                    mem[windex][i] <= wdata[i];
                end
            end
        end
    end

    // ----------------------------------------
    // Read ports

    // Read-first so a read on the write edge returns the old row
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            port0_rdata <= '0;
            port1_rdata <= '0;
        end else begin
            // Data holds while the enable is low
            if (port0_ren) begin
                port0_rdata <= mem[port0_rindex];
            end
            if (port1_ren) begin
                port1_rdata <= mem[port1_rindex];
            end
        end
    end

endmodule

// ==== rtl/mdpt_index_hash.sv ====
`timescale 1ns/1ps

module mdpt_index_hash #(
    parameter int MDPT_SETS  = mdpt_pkg::DEFAULT_MDPT_SETS,
    parameter int ASID_WIDTH = mdpt_pkg::DEFAULT_ASID_WIDTH
) (
    input  mdpt_pkg::pc_view_t        pc,
    input  logic [ASID_WIDTH-1:0]     asid,
    output logic [$clog2(MDPT_SETS)-1:0] index
);

    localparam int INDEX_WIDTH = $clog2(MDPT_SETS);
    // PC bits 31..4 take part in the fold
    localparam int UPPER_WIDTH = 28;
    localparam int NUM_CHUNKS  = (UPPER_WIDTH + INDEX_WIDTH - 1) / INDEX_WIDTH;
    localparam int PAD_WIDTH   = NUM_CHUNKS * INDEX_WIDTH;

    logic [PAD_WIDTH-1:0]   upper_padded;
    logic [INDEX_WIDTH-1:0] asid_fit;
    logic [INDEX_WIDTH-1:0] folded;

    // Last chunk gets zero padding on top
    assign upper_padded = PAD_WIDTH'(pc.flat[31:4]);

    // ASID zero-extended or truncated to the index width
    assign asid_fit = INDEX_WIDTH'(asid);

    always_comb begin
        folded = '0;
        for (int c = 0; c < NUM_CHUNKS; c++) begin
            folded = folded ^ upper_padded[c*INDEX_WIDTH +: INDEX_WIDTH];
        end
    end

    assign index = folded ^ asid_fit;

endmodule

// ==== rtl/mdpt_update_if.sv ====
`timescale 1ns/1ps

interface mdpt_update_if #(
    parameter int ASID_WIDTH = mdpt_pkg::DEFAULT_ASID_WIDTH
);
    import mdpt_pkg::*;

    // One resolved dependence outcome per valid cycle with no ready
    logic                  valid;
    pc_view_t              start_pc;
    logic [ASID_WIDTH-1:0] asid;
    logic                  dep_truth;

    // Driving side
    modport src (
        output valid, start_pc, asid, dep_truth
    );

    // Training side inside the table
    modport sink (
        input valid, start_pc, asid, dep_truth
    );

endinterface

// ==== rtl/mdpt_pkg.sv ====
package mdpt_pkg;

    // ----------------------------------------
    // Block geometry

    // Instruction slots per fetch block as fixed by the slot field below
    localparam int MDPT_ENTRIES_PER_BLOCK = 8;

    // Width of the slot number inside a block
    localparam int LOG_MDPT_ENTRIES_PER_BLOCK = 3;

    // ----------------------------------------
    // Default sizing

    // Number of sets in the table
    localparam int DEFAULT_MDPT_SETS = 512;

    // Address-space ID width
    localparam int DEFAULT_ASID_WIDTH = 9;

    // ----------------------------------------
    // Program counter views

    // One 32-bit PC seen two ways
    //   flat is the whole word folded by the index hash
    //   fields splits out the upper bits, the slot and the halfword bit
    typedef union packed {
        logic [31:0] flat;
        struct packed {
            // Block address above the slot field
            logic [27:0]                           upper;
            // Instruction slot within the fetch block
            logic [LOG_MDPT_ENTRIES_PER_BLOCK-1:0] slot;
            // Compressed instruction offset
            logic                                  halfword;
        } fields;
    } pc_view_t;

endpackage
